// File: list.f
+incdir+tests
verilog/bp_pkg.sv
verilog/sample_strobe.sv
verilog/window_accum.sv
verilog/pkt_fifo.sv
verilog/bp_reg.sv
verilog/bp_logger_top.sv
tests/tb_bp_logger.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_bp_logger -f list.f -o sim_tb --Mdir obj_dir
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation failed"
  exit 1
fi
grep -q "=== PASS ===" sim.log
echo "Simulation passed"

// File: tests/tb_bp_tasks.svh
// Expected values straight from the register map and window rules
function automatic byte_t ro_value(input addr_t a);
  case (a)
    ADDR_PKTFIFO_DEPTH:         return byte_t'(PKTFIFO_DEPTH);
    ADDR_MAX_WINDOW_LENGTH_EXP: return byte_t'(MAX_WINDOW_LENGTH_EXP);
    ADDR_LOGDROP_PRECISION:     return byte_t'(WINDOW_PRECISION);
    ADDR_MAX_SAMPLE_PERIOD_EXP: return byte_t'(MAX_SAMPLE_PERIOD_EXP);
    ADDR_MAX_SAMPLE_JITTER_EXP: return byte_t'(MAX_SAMPLE_JITTER_EXP);
    default:                    return 8'h00;
  endcase
endfunction

function automatic byte_t rw_mask(input addr_t a, input byte_t d);
  if (a == ADDR_WINDOW_SHAPE)
    return d & 8'h01;  // One bit shape
  return d & 8'h1f;    // Exponents are 5 bits
endfunction

function automatic result_t rect_model(input sample_t s, input int len_exp);
  return result_t'(s) << len_exp;
endfunction

function automatic result_t logdrop_model(input sample_t s, input int len_exp, input int windows);
  result_t acc;
  acc = '0;
  for (int i = 0; i < (windows << len_exp); i++) begin
    acc = acc - (acc >> len_exp) + result_t'(s);
  end
  return acc;
endfunction

task automatic check_byte(input byte_t got, input byte_t exp, input string what);
  check_count++;
  if (got !== exp) begin
    err_count++;
    $display("FAILED %0t: %s returned %02h, expected %02h", $time, what, got, exp);
  end
endtask

task automatic check_result(input result_t got, input result_t exp, input string what);
  check_count++;
  if (got !== exp) begin
    err_count++;
    $display("FAILED %0t: %s returned %08h, expected %08h", $time, what, got, exp);
  end
endtask

task automatic check_count_range(input int got, input int lo, input int hi, input string what);
  check_count++;
  if (got < lo || got > hi) begin
    err_count++;
    $display("FAILED %0t: %s is %0d, expected %0d to %0d", $time, what, got, lo, hi);
  end
endtask

// All pipe tasks start and end on a falling edge
task automatic send_byte(input byte_t b);
  logic taken;
  taken       = 1'b0;
  bp_in_data  = b;
  bp_in_valid = 1'b1;
  while (!taken) begin
    #2;
    taken = bp_in_ready;  // Settled value seen by the next rising edge
    @(negedge clk);
  end
  bp_in_valid = 1'b0;
endtask

task automatic recv_byte(output byte_t b, output int waited);
  logic got;
  got    = 1'b0;
  waited = 0;
  b      = '0;
  while (!got) begin
    #2;
    if (bp_out_valid && bp_out_ready) begin
      got = 1'b1;
      b   = bp_out_data;
    end else begin
      waited++;
    end
    @(negedge clk);
  end
endtask

task automatic write_reg(input addr_t a, input byte_t d, output byte_t rb);
  int w;
  send_byte({1'b1, a});
  send_byte(d);
  recv_byte(rb, w);
endtask

task automatic read_reg(input addr_t a, output byte_t rb, output int waited);
  send_byte({1'b0, a});
  recv_byte(rb, waited);
endtask

task automatic read_result(output result_t r);
  byte_t b;
  int    w;
  for (int i = 0; i < 4; i++) begin
    read_reg(ADDR_PKTFIFO_RD, b, w);
    r[8*i +: 8] = b;  // Least significant byte first
  end
endtask

task automatic configure(input int p, input int l, input window_shape_e shape,
                         input int jit, input sample_t s);
  byte_t rb;
  write_reg(ADDR_SAMPLE_PERIOD_EXP, 8'd16, rb);  // Park strobes
  write_reg(ADDR_WINDOW_SHAPE, byte_t'(shape), rb);
  write_reg(ADDR_WINDOW_LENGTH_EXP, byte_t'(l), rb);
  write_reg(ADDR_SAMPLE_JITTER_EXP, byte_t'(jit), rb);
  write_reg(ADDR_PKTFIFO_FLUSH, 8'd0, rb);
  sample = s;
  write_reg(ADDR_SAMPLE_PERIOD_EXP, byte_t'(p), rb);  // Restart counters
endtask

task automatic run_row(input row_t r);
  byte_t   b;
  int      w;
  int      n;
  time     t_start;
  result_t got;
  result_t got2;
  result_t exp_long;
  case (r.kind)
    K_READ: begin
      read_reg(r.addr, b, w);
      check_byte(b, r.exp_val[7:0], $sformatf("read of addr %0d", r.addr));
    end
    K_WRITE: begin
      write_reg(r.addr, r.data, b);
      check_byte(b, r.exp_val[7:0], $sformatf("write of addr %0d", r.addr));
    end
    K_RECT: begin
      configure(r.addr, r.data, SHAPE_RECTANGULAR, 0, r.sample);
      read_result(got);
      check_result(got, r.exp_val, "rectangular window");
    end
    K_LOGDROP: begin
      configure(r.addr, r.data, SHAPE_LOGDROP, 0, r.sample);
      read_result(got);
      check_result(got, r.exp_val, "logdrop first window");
      read_result(got);
      check_result(got, logdrop_model(r.sample, r.data, 2), "logdrop second window");
    end
    K_BURST: begin
      configure(r.addr, r.data, SHAPE_RECTANGULAR, 0, r.sample);
      write_reg(ADDR_BURST, 8'd8, b);
      check_byte(b, 8'd8, "burst count readback");
      send_byte({1'b0, ADDR_PKTFIFO_RD});
      for (int i = 0; i < 8; i++) begin
        recv_byte(b, w);
        if (i < 4)
          got[8*i +: 8] = b;
        else
          got2[8*(i-4) +: 8] = b;
      end
      check_result(got, r.exp_val, "burst result 0");
      check_result(got2, r.exp_val, "burst result 1");
      // Let a few more results queue up so the flush has data to drop
      repeat (3 << (r.addr + r.data)) @(negedge clk);
      // Longer window leaves a quiet gap after the flush
      write_reg(ADDR_WINDOW_LENGTH_EXP, 8'd6, b);
      write_reg(ADDR_PKTFIFO_FLUSH, 8'd0, b);
      read_reg(ADDR_PKTFIFO_RD, b, w);
      check_count++;
      if (w < STALL_MIN) begin
        err_count++;
        $display("Read after flush got data after %0d cycles instead of stalling", w);
      end
      exp_long = rect_model(r.sample, 6);
      check_byte(b, exp_long[7:0], "first byte after flush");
    end
    K_JITTER: begin
      write_reg(ADDR_PRNG_SEED, r.data, b);
      check_byte(b, 8'h00, "seed write readback");
      configure(r.addr, JIT_LEN_EXP, SHAPE_RECTANGULAR, 3, r.sample);
      t_start = $time;
      n = 0;
      while ($time - t_start < JIT_CYCLES * 2 * CLK_HALF) begin
        read_result(got);
        if ($time - t_start <= JIT_CYCLES * 2 * CLK_HALF)
          n++;
        check_result(got, r.exp_val, "jittered window");
      end
      // One window lasts 2^L strobes of 2^P to 2^P+7 cycles
      check_count_range(n,
        JIT_CYCLES / ((1 << JIT_LEN_EXP) * ((1 << r.addr) + 7)) - 1,
        JIT_CYCLES / ((1 << JIT_LEN_EXP) * (1 << r.addr)) + 1,
        "results in jitter window");
    end
    default: begin
      err_count++;
      $display("Unknown row kind %0d in the stimulus table", r.kind);
    end
  endcase
endtask

// File: tests/tb_bp_logger.sv
`timescale 1ns/100ps

module tb_bp_logger;
  import bp_pkg::*;

  localparam int MAX_WINDOW_LENGTH_EXP = 16;
  localparam int MAX_SAMPLE_PERIOD_EXP = 16;
  localparam int MAX_SAMPLE_JITTER_EXP = 8;
  localparam int WINDOW_PRECISION      = 32;
  localparam int PKTFIFO_DEPTH         = 64;

  localparam int CLK_HALF    = 4;
  localparam int ROW_TIME_NS = 20000;  // Watchdog budget per table row
  localparam int STALL_MIN   = 100;    // Cycles a post-flush read must wait
  localparam int JIT_CYCLES  = 2000;   // Counting window of the jitter row
  localparam int JIT_LEN_EXP = 2;

  // Row kinds
  localparam int K_READ    = 0;
  localparam int K_WRITE   = 1;
  localparam int K_RECT    = 2;  // addr is period exp, data is window exp
  localparam int K_LOGDROP = 3;
  localparam int K_BURST   = 4;
  localparam int K_JITTER  = 5;  // addr is period exp, data is seed

  typedef struct {
    int      kind;
    addr_t   addr;
    byte_t   data;
    sample_t sample;
    result_t exp_val;
  } row_t;

  logic    clk;
  logic    reset;
  sample_t sample;
  byte_t   bp_in_data;
  logic    bp_in_valid;
  logic    bp_in_ready;
  byte_t   bp_out_data;
  logic    bp_out_valid;
  logic    bp_out_ready;

  int      seed = 10787;
  int      err_count;
  int      check_count;
  int      n_rows;
  logic    ready_random;
  row_t    rows[$];

  bp_logger_top #(
    .MAX_WINDOW_LENGTH_EXP (MAX_WINDOW_LENGTH_EXP),
    .MAX_SAMPLE_PERIOD_EXP (MAX_SAMPLE_PERIOD_EXP),
    .MAX_SAMPLE_JITTER_EXP (MAX_SAMPLE_JITTER_EXP),
    .WINDOW_PRECISION      (WINDOW_PRECISION),
    .PKTFIFO_DEPTH         (PKTFIFO_DEPTH)
  ) uut (
    .i_clk      (clk),
    .i_reset    (reset),
    .i_sample   (sample),
    .i_bp_data  (bp_in_data),
    .i_bp_valid (bp_in_valid),
    .o_bp_ready (bp_in_ready),
    .o_bp_data  (bp_out_data),
    .o_bp_valid (bp_out_valid),
    .i_bp_ready (bp_out_ready)
  );

  `include "tb_bp_tasks.svh"

  task automatic add_row(input int k, input addr_t a, input byte_t d, input sample_t s,
                         input result_t e);
    row_t r;
    r.kind    = k;
    r.addr    = a;
    r.data    = d;
    r.sample  = s;
    r.exp_val = e;
    rows.push_back(r);
  endtask

  task automatic build_rows();
    add_row(K_READ, ADDR_BURST, 8'h00, 8'h00, 32'd0);
    for (int a = 4; a <= 8; a++) begin
      add_row(K_READ, addr_t'(a), 8'h00, 8'h00, result_t'(ro_value(addr_t'(a))));
    end
    add_row(K_READ, 7'd13, 8'h00, 8'h00, 32'd0);  // Above ADDR_REG_HI
    add_row(K_READ, 7'h7f, 8'h00, 8'h00, 32'd0);
    // Period stays at 16 so no results pile up meanwhile
    add_row(K_WRITE, ADDR_SAMPLE_PERIOD_EXP, 8'hf0, 8'h00,
            result_t'(rw_mask(ADDR_SAMPLE_PERIOD_EXP, 8'hf0)));
    add_row(K_WRITE, ADDR_SAMPLE_JITTER_EXP, 8'h25, 8'h00,
            result_t'(rw_mask(ADDR_SAMPLE_JITTER_EXP, 8'h25)));
    add_row(K_WRITE, ADDR_WINDOW_LENGTH_EXP, 8'he3, 8'h00,
            result_t'(rw_mask(ADDR_WINDOW_LENGTH_EXP, 8'he3)));
    add_row(K_WRITE, ADDR_WINDOW_SHAPE, 8'hfe, 8'h00,
            result_t'(rw_mask(ADDR_WINDOW_SHAPE, 8'hfe)));
    add_row(K_READ, ADDR_WINDOW_LENGTH_EXP, 8'h00, 8'h00, 32'd3);
    add_row(K_READ, ADDR_WINDOW_SHAPE, 8'h00, 8'h00, 32'd0);
    add_row(K_READ, ADDR_SAMPLE_PERIOD_EXP, 8'h00, 8'h00, 32'd16);
    add_row(K_READ, ADDR_SAMPLE_JITTER_EXP, 8'h00, 8'h00, 32'd5);
    add_row(K_RECT, 7'd2, 8'd3, 8'ha7, rect_model(8'ha7, 3));
    add_row(K_RECT, 7'd1, 8'd5, 8'hff, rect_model(8'hff, 5));
    add_row(K_LOGDROP, 7'd3, 8'd2, 8'd200, logdrop_model(8'd200, 2, 1));
    add_row(K_BURST, 7'd2, 8'd2, 8'h5f, rect_model(8'h5f, 2));
    add_row(K_JITTER, 7'd4, 8'h9d, 8'h33, rect_model(8'h33, JIT_LEN_EXP));
  endtask

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // Host output side, mostly ready
  initial begin
    bp_out_ready = 1'b1;
    wait (ready_random);
    forever begin
      @(negedge clk);
      bp_out_ready = (($random(seed) & 3) != 0);
    end
  end

  initial begin
    wait (n_rows > 0);
    #(n_rows * ROW_TIME_NS);
    $display("Timeout: the test table did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    byte_t rb;
    reset        = 1'b1;
    sample       = '0;
    bp_in_data   = '0;
    bp_in_valid  = 1'b0;
    ready_random = 1'b0;
    err_count    = 0;
    check_count  = 0;
    build_rows();
    n_rows = rows.size();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // Zero config strobes every cycle, slow it down first
    write_reg(ADDR_SAMPLE_PERIOD_EXP, 8'd16, rb);
    write_reg(ADDR_PKTFIFO_FLUSH, 8'd0, rb);
    ready_random = 1'b1;
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    repeat (4) @(negedge clk);
    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: verilog/bp_logger_top.sv
`timescale 1ns/100ps

module bp_logger_top #(
  parameter int MAX_WINDOW_LENGTH_EXP = 16,
  parameter int MAX_SAMPLE_PERIOD_EXP = 16,
  parameter int MAX_SAMPLE_JITTER_EXP = 8,
  parameter int WINDOW_PRECISION      = 32,
  parameter int PKTFIFO_DEPTH         = 64
) (
  input  logic            i_clk,
  input  logic            i_reset,
  input  bp_pkg::sample_t i_sample,
  input  bp_pkg::byte_t   i_bp_data,
  input  logic            i_bp_valid,
  output logic            o_bp_ready,
  output bp_pkg::byte_t   o_bp_data,
  output logic            o_bp_valid,
  input  logic            i_bp_ready
);
  import bp_pkg::*;

  cfg_t    cfg;
  logic    cfg_wr;
  byte_t   seed_byte;
  logic    seed_valid;
  logic    strobe;
  result_t result;
  logic    result_valid;
  byte_t   pktfifo_data;
  logic    pktfifo_empty;
  logic    pktfifo_pop;
  logic    pktfifo_flush;

  sample_strobe #(
    .MAX_SAMPLE_PERIOD_EXP (MAX_SAMPLE_PERIOD_EXP),
    .MAX_SAMPLE_JITTER_EXP (MAX_SAMPLE_JITTER_EXP)
  ) u_strobe (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_cfg        (cfg),
    .i_cfg_wr     (cfg_wr),
    .i_seed_byte  (seed_byte),
    .i_seed_valid (seed_valid),
    .o_strobe     (strobe)
  );

  window_accum #(
    .MAX_WINDOW_LENGTH_EXP (MAX_WINDOW_LENGTH_EXP),
    .WINDOW_PRECISION      (WINDOW_PRECISION)
  ) u_window (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_cfg          (cfg),
    .i_cfg_wr       (cfg_wr),
    .i_strobe       (strobe),
    .i_sample       (i_sample),
    .o_result       (result),
    .o_result_valid (result_valid)
  );

  pkt_fifo #(
    .PKTFIFO_DEPTH (PKTFIFO_DEPTH)
  ) u_fifo (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_result       (result),
    .i_result_valid (result_valid),
    .i_pop          (pktfifo_pop),
    .i_flush        (pktfifo_flush),
    .o_data         (pktfifo_data),
    .o_empty        (pktfifo_empty)
  );

  bp_reg #(
    .MAX_WINDOW_LENGTH_EXP (MAX_WINDOW_LENGTH_EXP),
    .MAX_SAMPLE_PERIOD_EXP (MAX_SAMPLE_PERIOD_EXP),
    .MAX_SAMPLE_JITTER_EXP (MAX_SAMPLE_JITTER_EXP),
    .WINDOW_PRECISION      (WINDOW_PRECISION),
    .PKTFIFO_DEPTH         (PKTFIFO_DEPTH)
  ) u_reg (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .i_bp_data       (i_bp_data),
    .i_bp_valid      (i_bp_valid),
    .o_bp_ready      (o_bp_ready),
    .o_bp_data       (o_bp_data),
    .o_bp_valid      (o_bp_valid),
    .i_bp_ready      (i_bp_ready),
    .i_pktfifo_data  (pktfifo_data),
    .i_pktfifo_empty (pktfifo_empty),
    .o_pktfifo_pop   (pktfifo_pop),
    .o_pktfifo_flush (pktfifo_flush),
    .o_cfg           (cfg),
    .o_cfg_wr        (cfg_wr),
    .o_seed_byte     (seed_byte),
    .o_seed_valid    (seed_valid)
  );

endmodule

// File: verilog/bp_pkg.sv
package bp_pkg;

  typedef logic [7:0]  byte_t;    // One byte on either pipe
  typedef logic [7:0]  sample_t;  // External sample input
  typedef logic [31:0] result_t;  // Window result, WINDOW_PRECISION bits
  typedef logic [6:0]  addr_t;    // Address field of a command byte

  // Register map
  localparam addr_t ADDR_BURST                 = 7'd0;
  localparam addr_t ADDR_PKTFIFO_RD            = 7'd1;   // Pops the FIFO
  localparam addr_t ADDR_PKTFIFO_FLUSH         = 7'd2;   // WO
  localparam addr_t ADDR_PRNG_SEED             = 7'd3;   // WO
  localparam addr_t ADDR_PKTFIFO_DEPTH         = 7'd4;   // RO
  localparam addr_t ADDR_MAX_WINDOW_LENGTH_EXP = 7'd5;   // RO
  localparam addr_t ADDR_LOGDROP_PRECISION     = 7'd6;   // RO
  localparam addr_t ADDR_MAX_SAMPLE_PERIOD_EXP = 7'd7;   // RO
  localparam addr_t ADDR_MAX_SAMPLE_JITTER_EXP = 7'd8;   // RO
  localparam addr_t ADDR_WINDOW_LENGTH_EXP     = 7'd9;   // RW
  localparam addr_t ADDR_WINDOW_SHAPE          = 7'd10;  // RW
  localparam addr_t ADDR_SAMPLE_PERIOD_EXP     = 7'd11;  // RW
  localparam addr_t ADDR_SAMPLE_JITTER_EXP     = 7'd12;  // RW
  localparam addr_t ADDR_REG_HI                = 7'd12;

  typedef enum logic {
    SHAPE_RECTANGULAR = 1'b0,
    SHAPE_LOGDROP     = 1'b1
  } window_shape_e;

  // Holds any of the MAX_*_EXP limits, the largest being 16
  typedef logic [4:0] exp_t;

  // RW configuration, 16 bits
  typedef struct packed {
    exp_t          window_length_exp;
    window_shape_e window_shape;
    exp_t          sample_period_exp;
    exp_t          sample_jitter_exp;
  } cfg_t;

endpackage

// File: verilog/bp_reg.sv
`timescale 1ns/100ps

module bp_reg #(
  parameter int MAX_WINDOW_LENGTH_EXP = 16,
  parameter int MAX_SAMPLE_PERIOD_EXP = 16,
  parameter int MAX_SAMPLE_JITTER_EXP = 8,
  parameter int WINDOW_PRECISION      = 32,
  parameter int PKTFIFO_DEPTH         = 64
) (
  input  logic          i_clk,
  input  logic          i_reset,

  input  bp_pkg::byte_t i_bp_data,
  input  logic          i_bp_valid,
  output logic          o_bp_ready,
  output bp_pkg::byte_t o_bp_data,
  output logic          o_bp_valid,
  input  logic          i_bp_ready,

  input  bp_pkg::byte_t i_pktfifo_data,
  input  logic          i_pktfifo_empty,
  output logic          o_pktfifo_pop,
  output logic          o_pktfifo_flush,

  output bp_pkg::cfg_t  o_cfg,
  output logic          o_cfg_wr,
  output bp_pkg::byte_t o_seed_byte,
  output logic          o_seed_valid
);
  import bp_pkg::*;

  logic  wr_q;        // Waiting for data byte(s)
  logic  rd_q;        // Return byte owed to host
  addr_t addr_q;
  byte_t burst_q;     // Down-counter
  byte_t burst_d;
  cfg_t  cfg_q;
  cfg_t  cfg_d;
  byte_t rd_data_q;
  byte_t rd_data_d;
  logic  rd_valid_q;

  logic  in_acc;
  logic  out_acc;
  logic  cmd_wr;
  addr_t cmd_addr;
  logic  txn_begin;
  logic  do_write;
  logic  in_burst;
  logic  in_burst_rd;
  logic  burst_last;
  logic  wr_done;
  logic  rd_more;
  logic  stall;
  logic  fetch_req;
  logic  fetch_ok;
  addr_t fetch_addr;
  logic  fetch_fifo;

  always_comb begin
    in_acc      = i_bp_valid && o_bp_ready;
    out_acc     = o_bp_valid && i_bp_ready;
    cmd_wr      = i_bp_data[7];
    cmd_addr    = i_bp_data[6:0];
    txn_begin   = !wr_q && in_acc;
    do_write    = wr_q && in_acc;
    in_burst    = (burst_q != '0) && (addr_q != ADDR_BURST);
    in_burst_rd = in_burst && rd_q;
    burst_last  = (burst_q == 8'd1);
    wr_done     = do_write && (!in_burst || burst_last); // Readback after last data byte
    rd_more     = in_burst_rd && !burst_last;
    stall       = rd_q && !rd_valid_q; // Only while FIFO is empty
  end

  // Destination controls the flow
  assign o_bp_ready = i_bp_ready && !in_burst_rd && !stall;

  // Fetch a return byte, retried every cycle while stalled
  always_comb begin
    fetch_req  = (txn_begin && !cmd_wr) || wr_done || stall || (out_acc && rd_more);
    fetch_addr = txn_begin ? cmd_addr : addr_q;
    fetch_fifo = (fetch_addr == ADDR_PKTFIFO_RD);
    fetch_ok   = fetch_req && !(fetch_fifo && i_pktfifo_empty);
  end

  assign o_pktfifo_pop   = fetch_ok && fetch_fifo;
  assign o_pktfifo_flush = do_write && (addr_q == ADDR_PKTFIFO_FLUSH);
  assign o_seed_byte     = i_bp_data;
  assign o_seed_valid    = do_write && (addr_q == ADDR_PRNG_SEED);

  always_comb begin
    cfg_d = cfg_q;
    if (do_write) begin
      case (addr_q)
        ADDR_WINDOW_LENGTH_EXP: cfg_d.window_length_exp = exp_t'(i_bp_data);
        ADDR_WINDOW_SHAPE:      cfg_d.window_shape      = window_shape_e'(i_bp_data[0]);
        ADDR_SAMPLE_PERIOD_EXP: cfg_d.sample_period_exp = exp_t'(i_bp_data);
        ADDR_SAMPLE_JITTER_EXP: cfg_d.sample_jitter_exp = exp_t'(i_bp_data);
        default: ;
      endcase
    end
  end

  always_comb begin
    if (do_write && (addr_q == ADDR_BURST))
      burst_d = i_bp_data;
    else if ((do_write && in_burst) || (out_acc && in_burst_rd))
      burst_d = burst_q - 8'd1;
    else
      burst_d = burst_q;
  end

  // Read mux sees next-state values so a write returns what it stored
  always_comb begin
    rd_data_d = '0; // Out-of-range and WO locations
    if (fetch_addr <= ADDR_REG_HI) begin
      case (fetch_addr)
        ADDR_BURST:                 rd_data_d = burst_d;
        ADDR_PKTFIFO_RD:            rd_data_d = i_pktfifo_data;
        ADDR_PKTFIFO_DEPTH:         rd_data_d = byte_t'(PKTFIFO_DEPTH);
        ADDR_MAX_WINDOW_LENGTH_EXP: rd_data_d = byte_t'(MAX_WINDOW_LENGTH_EXP);
        ADDR_LOGDROP_PRECISION:     rd_data_d = byte_t'(WINDOW_PRECISION);
        ADDR_MAX_SAMPLE_PERIOD_EXP: rd_data_d = byte_t'(MAX_SAMPLE_PERIOD_EXP);
        ADDR_MAX_SAMPLE_JITTER_EXP: rd_data_d = byte_t'(MAX_SAMPLE_JITTER_EXP);
        ADDR_WINDOW_LENGTH_EXP:     rd_data_d = byte_t'(cfg_d.window_length_exp);
        ADDR_WINDOW_SHAPE:          rd_data_d = byte_t'(cfg_d.window_shape);
        ADDR_SAMPLE_PERIOD_EXP:     rd_data_d = byte_t'(cfg_d.sample_period_exp);
        ADDR_SAMPLE_JITTER_EXP:     rd_data_d = byte_t'(cfg_d.sample_jitter_exp);
        default:                    rd_data_d = '0;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_q       <= 1'b0;
      rd_q       <= 1'b0;
      addr_q     <= '0;
      burst_q    <= '0;
      cfg_q      <= '0;
      rd_valid_q <= 1'b0;
      o_cfg_wr   <= 1'b0;
    end else begin
      if (txn_begin && cmd_wr)
        wr_q <= 1'b1;
      else if (wr_done)
        wr_q <= 1'b0;

      if ((txn_begin && !cmd_wr) || wr_done)
        rd_q <= 1'b1;
      else if (out_acc && !rd_more)
        rd_q <= 1'b0;

      if (txn_begin)
        addr_q <= cmd_addr;

      if (fetch_ok)
        rd_valid_q <= 1'b1;
      else if (fetch_req || out_acc)
        rd_valid_q <= 1'b0;

      burst_q  <= burst_d;
      cfg_q    <= cfg_d;
      // Lands with the new cfg value, restarts strobe and window
      o_cfg_wr <= do_write && (addr_q >= ADDR_WINDOW_LENGTH_EXP) && (addr_q <= ADDR_REG_HI);
    end
  end

  always_ff @(posedge i_clk) begin
    if (fetch_ok)
      rd_data_q <= rd_data_d;
  end

  assign o_bp_data  = rd_data_q;
  assign o_bp_valid = rd_valid_q;
  assign o_cfg      = cfg_q;

  // Return byte is held until the host takes it
  a_out_stable: assert property (@(posedge i_clk) disable iff (i_reset)
    o_bp_valid && !i_bp_ready |=> o_bp_valid && $stable(o_bp_data));

endmodule

// File: verilog/pkt_fifo.sv
`timescale 1ns/100ps

module pkt_fifo #(
  parameter int PKTFIFO_DEPTH = 64 // Bytes, not results
) (
  input  logic            i_clk,
  input  logic            i_reset,
  input  bp_pkg::result_t i_result,
  input  logic            i_result_valid,
  input  logic            i_pop,
  input  logic            i_flush,
  output bp_pkg::byte_t   o_data,
  output logic            o_empty
);
  import bp_pkg::*;

  localparam int PTR_W = $clog2(PKTFIFO_DEPTH);
  localparam int CNT_W = $clog2(PKTFIFO_DEPTH + 1);

  byte_t            mem [PKTFIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] free;
  logic             push;
  logic             pop;

  // Circular index advance, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr,
                                               input int unsigned      k);
    int unsigned sum;
    sum = ptr + k;
    if (sum >= PKTFIFO_DEPTH)
      sum = sum - PKTFIFO_DEPTH;
    return PTR_W'(sum);
  endfunction

  always_comb begin
    free = CNT_W'(PKTFIFO_DEPTH) - count_q;
    push = i_result_valid && (free >= CNT_W'(4)) && !i_flush; // Whole result or nothing
    pop  = i_pop && !o_empty && !i_flush;
  end

  assign o_empty = (count_q == '0);
  assign o_data  = mem[rd_ptr_q];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (i_flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push)
        wr_ptr_q <= ptr_add(wr_ptr_q, 4);
      if (pop)
        rd_ptr_q <= ptr_add(rd_ptr_q, 1);
      count_q <= count_q + (push ? CNT_W'(4) : '0) - CNT_W'(pop);
    end
  end

  // Least significant byte goes first
  always_ff @(posedge i_clk) begin
    if (push) begin
      for (int i = 0; i < 4; i++) begin
        mem[ptr_add(wr_ptr_q, i)] <= i_result[8*i +: 8];
      end
    end
  end

  // Register block must only pop when data is present
  a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_reset)
    i_pop |-> !o_empty);

  // Host side has to keep up with the window rate
  a_no_result_drop: assert property (@(posedge i_clk) disable iff (i_reset)
    i_result_valid && !i_flush |-> free >= CNT_W'(4));

endmodule

// File: verilog/sample_strobe.sv
`timescale 1ns/100ps

module sample_strobe #(
  parameter int MAX_SAMPLE_PERIOD_EXP = 16,
  parameter int MAX_SAMPLE_JITTER_EXP = 8
) (
  input  logic          i_clk,
  input  logic          i_reset,
  input  bp_pkg::cfg_t  i_cfg,
  input  logic          i_cfg_wr,
  input  bp_pkg::byte_t i_seed_byte,
  input  logic          i_seed_valid,
  output logic          o_strobe
);
  import bp_pkg::*;

  // Room for 2^MAX period plus a full 16b jitter
  localparam int CNT_W = MAX_SAMPLE_PERIOD_EXP + 2;
  localparam logic [15:0] LFSR_TAPS = 16'hB400;

  exp_t             period_exp;
  exp_t             jitter_exp;
  logic [15:0]      lfsr_q;
  logic [15:0]      lfsr_step;
  logic [15:0]      lfsr_seeded;
  logic [15:0]      jitter;
  logic [CNT_W-1:0] interval;
  logic [CNT_W-1:0] count_q;
  logic             reload;

  always_comb begin
    // Clamp exponents to the supported range
    period_exp = (i_cfg.sample_period_exp > exp_t'(MAX_SAMPLE_PERIOD_EXP)) ?
                 exp_t'(MAX_SAMPLE_PERIOD_EXP) : i_cfg.sample_period_exp;
    jitter_exp = (i_cfg.sample_jitter_exp > exp_t'(MAX_SAMPLE_JITTER_EXP)) ?
                 exp_t'(MAX_SAMPLE_JITTER_EXP) : i_cfg.sample_jitter_exp;
    jitter     = lfsr_q & ((16'd1 << jitter_exp) - 16'd1);
    interval   = (CNT_W'(1) << period_exp) + CNT_W'(jitter);
    lfsr_step  = {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? LFSR_TAPS : 16'd0);
    lfsr_seeded = {lfsr_q[7:0], i_seed_byte}; // Seed enters at the low end
    if (lfsr_seeded == 16'd0) begin
      lfsr_seeded = 16'd1; // Zero state would lock up
    end
    reload = (count_q == '0);
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      count_q  <= '0;
      o_strobe <= 1'b0;
      lfsr_q   <= 16'd1;
    end else begin
      if (i_cfg_wr) begin
        count_q  <= interval - CNT_W'(1); // Restart with new config
        o_strobe <= 1'b0;
      end else if (reload) begin
        count_q  <= interval - CNT_W'(1);
        o_strobe <= 1'b1;
      end else begin
        count_q  <= count_q - CNT_W'(1);
        o_strobe <= 1'b0;
      end

      if (i_seed_valid)
        lfsr_q <= lfsr_seeded;
      else if (reload && !i_cfg_wr)
        lfsr_q <= lfsr_step; // One step per strobe
    end
  end

  // Any period above one cycle keeps strobes apart
  a_strobe_single: assert property (@(posedge i_clk) disable iff (i_reset)
    o_strobe && (period_exp != '0) |=> !o_strobe);

endmodule

// File: verilog/window_accum.sv
`timescale 1ns/100ps

module window_accum #(
  parameter int MAX_WINDOW_LENGTH_EXP = 16,
  parameter int WINDOW_PRECISION      = 32
) (
  input  logic            i_clk,
  input  logic            i_reset,
  input  bp_pkg::cfg_t    i_cfg,
  input  logic            i_cfg_wr,
  input  logic            i_strobe,
  input  bp_pkg::sample_t i_sample,
  output bp_pkg::result_t o_result,
  output logic            o_result_valid
);
  import bp_pkg::*;

  localparam int CNT_W = MAX_WINDOW_LENGTH_EXP + 1;

  exp_t                        len_exp;
  logic [CNT_W-1:0]            last_idx;
  logic [CNT_W-1:0]            cnt_q;     // Samples taken in this window
  logic [WINDOW_PRECISION-1:0] acc_q;
  logic [WINDOW_PRECISION:0]   rect_sum;  // Carry bit kept for overflow check
  logic [WINDOW_PRECISION-1:0] drop_sum;
  logic [WINDOW_PRECISION-1:0] acc_next;
  logic                        logdrop;
  logic                        window_end;

  always_comb begin
    len_exp  = (i_cfg.window_length_exp > exp_t'(MAX_WINDOW_LENGTH_EXP)) ?
               exp_t'(MAX_WINDOW_LENGTH_EXP) : i_cfg.window_length_exp;
    last_idx = (CNT_W'(1) << len_exp) - CNT_W'(1);
    logdrop  = (i_cfg.window_shape == SHAPE_LOGDROP);

    rect_sum = {1'b0, acc_q} + (WINDOW_PRECISION+1)'(i_sample);
    // Leaky sum, drops 1/2^L of itself per sample
    drop_sum = acc_q - (acc_q >> len_exp) + WINDOW_PRECISION'(i_sample);
    acc_next = logdrop ? drop_sum : rect_sum[WINDOW_PRECISION-1:0];

    window_end = i_strobe && (cnt_q == last_idx);
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      cnt_q          <= '0;
      acc_q          <= '0;
      o_result_valid <= 1'b0;
    end else begin
      o_result_valid <= window_end && !i_cfg_wr;
      if (i_cfg_wr) begin
        cnt_q <= '0;
        acc_q <= '0;
      end else if (i_strobe) begin
        cnt_q <= window_end ? '0 : cnt_q + CNT_W'(1);
        if (window_end && !logdrop)
          acc_q <= '0; // Rectangular restarts each window
        else
          acc_q <= acc_next;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (window_end)
      o_result <= result_t'(acc_next);
  end

  // WINDOW_PRECISION must cover 8 + MAX_WINDOW_LENGTH_EXP bits
  a_rect_no_overflow: assert property (@(posedge i_clk) disable iff (i_reset)
    i_strobe && !logdrop |-> !rect_sum[WINDOW_PRECISION]);

endmodule
